//--- filelist.f
rtl/tile_pkg.sv
rtl/nest2_counter.sv
rtl/feature_buffer.sv
rtl/tile_out_queue.sv
rtl/tile_addr_gen.sv
rtl/tile_fetch_top.sv
verification/tb_tile_fetch.sv

//--- rtl/feature_buffer.sv
// On-chip feature buffer with one write port and one registered read port.
// Read data appears one cycle after rd_en; a same-address write returns old data.

`timescale 1ns/1ps

module feature_buffer (
    input  logic                        wr_en,
    input  logic [tile_pkg::addr_w-1:0] wr_addr,
    input  logic [tile_pkg::data_w-1:0] wr_data,

    input  logic                        rd_en,
    input  logic [tile_pkg::addr_w-1:0] rd_addr,
    output logic [tile_pkg::data_w-1:0] rd_data,

    input  logic                        clk
);

    import tile_pkg::*;

    logic [data_w-1:0] mem [buf_depth];

    ////////////////////
    // Write port.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////
    // Read port.

    // Sampled before this edge's write lands, hence read-old-data.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- rtl/nest2_counter.sv
// Two-level nested counter that walks a column index inside a row index.
// Rests at its maximum counts when idle; the first enable starts it at zero, zero.

`timescale 1ns/1ps

module nest2_counter #(
    parameter int cnt_w  = 8,
    parameter int n0_max = 8,
    parameter int n1_max = 4
) (
    input  logic             ena,
    input  logic             syn_rst,

    output logic [cnt_w-1:0] cnt0,
    output logic [cnt_w-1:0] cnt1,

    output logic             done,

    input  logic             clk,
    input  logic             rst
);

    logic cnt0_full;
    logic cnt1_full;
    logic full_q;

    ////////////////////
    // Full flags.

    // cnt0 is full on the last column of a row.
    assign cnt0_full = (cnt0 == cnt_w'(n0_max - 1));

    // The combined flag marks the last position of the whole walk.
    assign cnt1_full = (cnt1 == cnt_w'(n1_max - 1)) && cnt0_full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full_q <= 1'b0;
        end else begin
            full_q <= cnt1_full;
        end
    end

    // One-cycle pulse on the rising edge of the combined full flag.
    assign done = cnt1_full && !full_q;

    ////////////////////
    // Column count.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt0 <= cnt_w'(n0_max);
        end else if (syn_rst) begin
            cnt0 <= cnt_w'(n0_max);           // Back to the idle maximum.
        end else if (ena) begin
            if (cnt0 == cnt_w'(n0_max)) begin
                cnt0 <= '0;                   // Leave idle.
            end else if (cnt0_full) begin
                cnt0 <= '0;                   // Wrap at the end of a row.
            end else begin
                cnt0 <= cnt0 + 1'b1;
            end
        end
    end

    ////////////////////
    // Row count.

    // The row only moves when the column wraps, or when leaving idle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt1 <= cnt_w'(n1_max);
        end else if (syn_rst) begin
            cnt1 <= cnt_w'(n1_max);
        end else if (ena) begin
            if (cnt1 == cnt_w'(n1_max)) begin
                cnt1 <= '0;
            end else if (cnt0_full) begin
                if (cnt1 == cnt_w'(n1_max - 1)) begin
                    cnt1 <= '0;               // Roll back after the last position.
                end else begin
                    cnt1 <= cnt1 + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/tile_addr_gen.sv
// Accepts a tile base address and walks the tile row by row.
// Issues one buffer read per cycle while the output queue has room for it.

`timescale 1ns/1ps

module tile_addr_gen (
    input  logic                        cmd_valid,
    input  logic [tile_pkg::addr_w-1:0] cmd_base,
    output logic                        cmd_ready,

    input  logic [tile_pkg::qcnt_w-1:0] q_count,

    output logic                        rd_en,
    output logic [tile_pkg::addr_w-1:0] rd_addr,
    output logic                        rd_last,

    input  logic                        clk,
    input  logic                        rst
);

    import tile_pkg::*;

    logic [1:0]        state;
    logic [addr_w-1:0] base_q;
    logic              in_flight;   // A read was issued last cycle.
    logic              done_hold;   // Last position reached, read not yet issued.

    logic              ena;
    logic              syn_rst;
    logic [cnt_w-1:0]  cnt0;
    logic [cnt_w-1:0]  cnt1;
    logic              done;

    logic [qcnt_w:0]   pending;
    logic              credit_ok;
    logic              last_hit;
    logic [addr_w-1:0] row_off;
    logic [addr_w-1:0] col_off;

    nest2_counter #(
        .cnt_w  (cnt_w),
        .n0_max (tile_cols),
        .n1_max (tile_rows)
    ) nest2_counter_i (
        .ena     (ena),
        .syn_rst (syn_rst),
        .cnt0    (cnt0),
        .cnt1    (cnt1),
        .done    (done),
        .clk     (clk),
        .rst     (rst)
    );

    ////////////////////
    // Credit and read issue.

    // Words already in the queue plus the one still coming back from the buffer.
    assign pending   = {1'b0, q_count} + {{qcnt_w{1'b0}}, in_flight};
    assign credit_ok = (pending < (qcnt_w + 1)'(queue_depth));

    // The done pulse may fall on a stalled cycle, so it is held until used.
    assign last_hit = done || done_hold;

    assign rd_en   = (state == st_walk) && credit_ok;
    assign rd_last = rd_en && last_hit;

    assign row_off = addr_w'(cnt1 * row_stride);
    assign col_off = addr_w'(cnt0);
    assign rd_addr = base_q + row_off + col_off;  // Wraps at the buffer size.

    assign ena       = (state == st_prime) || rd_en;
    assign syn_rst   = rd_last;                    // Park the counter after the tile.
    assign cmd_ready = (state == st_idle);

    ////////////////////
    // Control FSM.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            in_flight <= 1'b0;
            done_hold <= 1'b0;
        end else begin
            in_flight <= rd_en;

            if (rd_last) begin
                done_hold <= 1'b0;
            end else if (done) begin
                done_hold <= 1'b1;
            end

            case (state)
                st_idle:  if (cmd_valid) state <= st_prime;
                st_prime: state <= st_walk;
                st_walk:  if (rd_last) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // Base address of the tile in progress.
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            base_q <= cmd_base;
        end
    end

endmodule

//--- rtl/tile_fetch_top.sv
// Tile fetch engine top level.
// Load the buffer, then give a base address; the tile comes out as a stream.

`timescale 1ns/1ps

module tile_fetch_top (
    input  logic                        load_valid,
    input  logic [tile_pkg::addr_w-1:0] load_addr,
    input  logic [tile_pkg::data_w-1:0] load_data,

    input  logic                        cmd_valid,
    input  logic [tile_pkg::addr_w-1:0] cmd_base,
    output logic                        cmd_ready,

    output logic                        out_valid,
    output logic [tile_pkg::data_w-1:0] out_data,
    output logic                        out_last,
    input  logic                        out_ready,

    input  logic                        clk,
    input  logic                        rst
);

    import tile_pkg::*;

    logic              rd_en;
    logic [addr_w-1:0] rd_addr;
    logic              rd_last;
    logic [data_w-1:0] rd_data;
    logic [qcnt_w-1:0] q_count;

    logic              rd_valid_q;   // rd_data holds a fresh word this cycle.
    logic              rd_last_q;

    feature_buffer feature_buffer_i (
        .wr_en   (load_valid),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .clk     (clk)
    );

    tile_addr_gen tile_addr_gen_i (
        .cmd_valid (cmd_valid),
        .cmd_base  (cmd_base),
        .cmd_ready (cmd_ready),
        .q_count   (q_count),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_last   (rd_last),
        .clk       (clk),
        .rst       (rst)
    );

    // Match the one-cycle read latency of the buffer.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid_q <= 1'b0;
            rd_last_q  <= 1'b0;
        end else begin
            rd_valid_q <= rd_en;
            rd_last_q  <= rd_last;
        end
    end

    tile_out_queue tile_out_queue_i (
        .in_valid  (rd_valid_q),
        .in_data   (rd_data),
        .in_last   (rd_last_q),
        .q_count   (q_count),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_ready (out_ready),
        .clk       (clk),
        .rst       (rst)
    );

endmodule

//--- rtl/tile_out_queue.sv
// Small FIFO between the feature buffer and the output stream.
// Holds each word with its last flag and reports its occupancy to the address generator.

`timescale 1ns/1ps

module tile_out_queue (
    input  logic                        in_valid,
    input  logic [tile_pkg::data_w-1:0] in_data,
    input  logic                        in_last,

    output logic [tile_pkg::qcnt_w-1:0] q_count,

    output logic                        out_valid,
    output logic [tile_pkg::data_w-1:0] out_data,
    output logic                        out_last,
    input  logic                        out_ready,

    input  logic                        clk,
    input  logic                        rst
);

    import tile_pkg::*;

    logic [data_w-1:0] data_mem [queue_depth];
    logic              last_mem [queue_depth];

    logic [qptr_w-1:0] wr_ptr;
    logic [qptr_w-1:0] rd_ptr;
    logic [qcnt_w-1:0] count;

    logic              push;
    logic              pop;

    assign push = in_valid;               // The credit check guarantees room.
    assign pop  = out_valid && out_ready;

    assign out_valid = (count != '0);
    assign out_data  = data_mem[rd_ptr];
    assign out_last  = last_mem[rd_ptr];

    // Occupancy once this cycle's pop has left, so a draining queue keeps full rate.
    assign q_count = count - qcnt_w'(pop);

    ////////////////////
    // Storage.

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_data;
            last_mem[wr_ptr] <= in_last;
        end
    end

    ////////////////////
    // Pointers and count.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == qptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == qptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither leave it unchanged.
            endcase
        end
    end

endmodule

//--- rtl/tile_pkg.sv
// Shared constants for the tile fetch engine.
// Every RTL file that needs the tile geometry imports this package.

package tile_pkg;

    ////////////////////
    // Buffer geometry.
    localparam int data_w    = 16;    // Width of one feature word.
    localparam int addr_w    = 10;    // Buffer address width.
    localparam int buf_depth = 1024;  // Number of words in the feature buffer.

    ////////////////////
    // Tile shape, fixed at build time.
    localparam int tile_cols  = 8;    // Words per tile row.
    localparam int tile_rows  = 4;    // Rows per tile.
    localparam int row_stride = 32;   // Words between two feature map rows.
    localparam int cnt_w      = 8;    // Must hold tile_cols and tile_rows.

    ////////////////////
    // Output queue.
    localparam int queue_depth = 2;
    localparam int qcnt_w      = $clog2(queue_depth + 1);  // Occupancy 0 to queue_depth.
    localparam int qptr_w      = (queue_depth > 1) ? $clog2(queue_depth) : 1;

    // Address generator FSM encoding.
    localparam logic [1:0] st_idle  = 2'd0;  // Waiting for a command.
    localparam logic [1:0] st_prime = 2'd1;  // Moving the counter out of idle.
    localparam logic [1:0] st_walk  = 2'd2;  // Issuing reads.

endpackage

//--- run_sim.sh
#!/bin/sh
# Builds the tile fetch testbench with Verilator and runs it.
# The exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_tile_fetch \
    -f filelist.f \
    -o sim_tile_fetch
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tile_fetch
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

//--- verification/tb_tile_fetch.sv
// Self-checking testbench for the tile fetch engine.
// Loads the buffer with random words, fetches tiles under several output
// conditions and compares every streamed word with a model of the buffer.

`timescale 1ns/1ps

module tb_tile_fetch;

    import tile_pkg::*;

    localparam int clk_period      = 10;
    localparam int tile_size       = tile_cols * tile_rows;
    localparam int num_tiles       = 7;
    localparam int stall_factor    = 8;     // Generous cycles per word under random stalls.
    localparam int watchdog_cycles = buf_depth + num_tiles * tile_size * stall_factor + 200;

    logic              clk;
    logic              rst;
    logic              load_valid;
    logic [addr_w-1:0] load_addr;
    logic [data_w-1:0] load_data;
    logic              cmd_valid;
    logic [addr_w-1:0] cmd_base;
    logic              cmd_ready;
    logic              out_valid;
    logic [data_w-1:0] out_data;
    logic              out_last;
    logic              out_ready;

    logic              read_issue;          // Buffer read strobe inside the DUT.

    int                seed = 9918;
    logic [data_w-1:0] model [buf_depth];   // Mirror of every buffer write.
    logic [data_w:0]   exp_q [$];           // Expected {last, data} in output order.
    int                accept_q [$];        // Acceptance cycle of each outstanding tile.

    int   cycle           = 0;
    int   accept_count    = 0;
    int   tile_count      = 0;
    int   word_idx        = 0;
    int   last_word_cycle = 0;
    int   reads_in_tile   = 0;
    logic busy            = 1'b0;
    logic full_rate;                         // Out_ready held high, so timing is exact.
    logic random_ready;

    tile_fetch_top tile_fetch_top_i (
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .cmd_valid  (cmd_valid),
        .cmd_base   (cmd_base),
        .cmd_ready  (cmd_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_ready  (out_ready),
        .clk        (clk),
        .rst        (rst)
    );

    assign read_issue = tile_fetch_top_i.rd_en;

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////
    // Error handling.

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Run stopped after an error.");
    endtask

    task automatic value_error(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        abort_run();
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: the tiles did not finish within %0d cycles.", watchdog_cycles);
        abort_run();
    end

    ////////////////////
    // Reference model.

    // Rows in order, columns in order within a row, addresses wrap at the buffer end.
    task automatic queue_tile(input logic [addr_w-1:0] base);
        int   a;
        logic last;
        for (int r = 0; r < tile_rows; r++) begin
            for (int c = 0; c < tile_cols; c++) begin
                a    = (int'(base) + r * row_stride + c) % buf_depth;
                last = (r == tile_rows - 1) && (c == tile_cols - 1);
                exp_q.push_back({last, model[addr_w'(a)]});
            end
        end
    endtask

    task automatic check_word();
        logic [data_w:0] exp_word;
        int              acc;
        if (exp_q.size() == 0) begin
            value_error("output word with no tile outstanding");
        end else begin
            exp_word = exp_q.pop_front();
            assert (out_data == exp_word[data_w-1:0])
                else value_error($sformatf("word %0d of tile %0d is %h, expected %h",
                                           word_idx, tile_count, out_data,
                                           exp_word[data_w-1:0]));
            assert (out_last == exp_word[data_w])
                else value_error($sformatf("out_last is %0b on word %0d of tile %0d",
                                           out_last, word_idx, tile_count));
            if (word_idx == 0) begin
                acc = accept_q.pop_front();
                // Valid three cycles after the accepting edge, sampled one edge later.
                if (full_rate) begin
                    assert (cycle - acc == 4)
                        else value_error($sformatf("first word after %0d cycles, expected 3",
                                                   cycle - acc - 1));
                end
            end else if (full_rate) begin
                assert (cycle == last_word_cycle + 1)
                    else value_error("gap between words with out_ready held high");
            end
            last_word_cycle = cycle;
            if (out_last) begin
                word_idx   = 0;
                tile_count = tile_count + 1;
            end else begin
                word_idx = word_idx + 1;
            end
        end
    endtask

    ////////////////////
    // Monitor.

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst) begin
            if (load_valid) begin
                model[load_addr] = load_data;
            end
            // Once cmd_ready is back, every read of the tile has been issued.
            if (busy && cmd_ready) begin
                assert (reads_in_tile == tile_size)
                    else value_error($sformatf("tile ended after %0d reads, expected %0d",
                                               reads_in_tile, tile_size));
                busy = 1'b0;
            end else if (busy && reads_in_tile == tile_size) begin
                // The cycle after the last read, cmd_ready must be high again.
                value_error("cmd_ready still low the cycle after the last read");
            end
            if (cmd_valid && cmd_ready) begin
                queue_tile(cmd_base);
                accept_q.push_back(cycle);
                accept_count  = accept_count + 1;
                reads_in_tile = 0;
                busy          = 1'b1;
            end
            if (read_issue) begin
                reads_in_tile = reads_in_tile + 1;
            end
            if (out_valid && out_ready) begin
                check_word();
            end
        end
    end

    // A stalled word stays put until it is taken.
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else value_error("out_data or out_last changed while stalled");

    ////////////////////
    // Stimulus.

    task automatic drive_ready();
        int rnd;
        if (random_ready) begin
            rnd       = $random(seed);
            out_ready = rnd[0];
        end else begin
            out_ready = 1'b1;
        end
    endtask

    // Leaves cmd_valid high on return, so the caller may offer the next command at once.
    task automatic issue_cmd(input logic [addr_w-1:0] base);
        int target;
        target    = accept_count + 1;
        cmd_valid = 1'b1;
        cmd_base  = base;
        while (accept_count < target) begin
            @(negedge clk);
            drive_ready();
        end
    endtask

    task automatic wait_tiles(input int target);
        while (tile_count < target) begin
            @(negedge clk);
            drive_ready();
        end
    endtask

    initial begin
        int rnd;
        rst          = 1'b1;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        cmd_valid    = 1'b0;
        cmd_base     = '0;
        out_ready    = 1'b0;
        full_rate    = 1'b0;
        random_ready = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        assert (cmd_ready === 1'b1 && out_valid === 1'b0)
            else value_error("DUT not idle after reset");

        for (int a = 0; a < buf_depth; a++) begin
            rnd        = $random(seed);
            load_valid = 1'b1;
            load_addr  = addr_w'(a);
            load_data  = rnd[data_w-1:0];
            @(negedge clk);
        end
        load_valid = 1'b0;
        @(negedge clk);
        assert (cmd_ready === 1'b1 && out_valid === 1'b0)
            else value_error("DUT left idle while the buffer was loaded");

        // Single tile at base zero with the output always ready.
        full_rate = 1'b1;
        out_ready = 1'b1;
        issue_cmd('0);
        cmd_valid = 1'b0;
        wait_tiles(1);

        // Random back-pressure.
        full_rate    = 1'b0;
        random_ready = 1'b1;
        issue_cmd(addr_w'(37));
        cmd_valid = 1'b0;
        wait_tiles(2);
        issue_cmd(addr_w'(300));
        cmd_valid = 1'b0;
        wait_tiles(3);
        issue_cmd(addr_w'(517));
        cmd_valid = 1'b0;
        wait_tiles(4);

        // Back-to-back commands, each offered while the previous tile is busy.
        random_ready = 1'b0;
        out_ready    = 1'b1;
        full_rate    = 1'b1;
        issue_cmd(addr_w'(64));
        issue_cmd(addr_w'(1000));        // Runs past the end of the buffer.
        issue_cmd(addr_w'(12));
        cmd_valid = 1'b0;
        wait_tiles(num_tiles);

        repeat (4) @(negedge clk);
        if (exp_q.size() != 0 || tile_count != num_tiles || out_valid) begin
            value_error($sformatf("%0d words still expected after %0d tiles",
                                  exp_q.size(), tile_count));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule
